// ==== vlog.f ====
common/core_pkg.sv
fetch/fetch_unit.sv
decode/inst_decode.sv
execute/alu_unit.sv
rtl/commit_unit.sv
rtl/fetch_perf.sv
rtl/core_top.sv
bench/core_tb_sva.sv
bench/core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := core_tb
FILELIST  := vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir

// ==== bench/core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 5;
    localparam int    MAX_PROG     = 32;
    localparam word_t START_ADDR   = 32'h0000_1000;

    // Instruction kinds for the program builder
    localparam int K_ADDI   = 0;
    localparam int K_ADD    = 1;
    localparam int K_SUB    = 2;
    localparam int K_AND    = 3;
    localparam int K_OR     = 4;
    localparam int K_XOR    = 5;
    localparam int K_SLT    = 6;
    localparam int K_LUI    = 7;
    localparam int K_BAD    = 8;
    localparam int K_EBREAK = 9;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 dcr_write_valid;
    dcr_addr_t            dcr_write_addr;
    word_t                dcr_write_data;
    logic                 icache_req_valid;
    addr_t                icache_req_addr;
    logic                 icache_req_ready;
    logic                 icache_rsp_valid;
    word_t                icache_rsp_data;
    logic                 icache_rsp_ready;
    logic                 sim_ebreak;
    word_t [NUM_REGS-1:0] sim_wb_value;
    logic                 busy;
    perf_ctr_t            perf_ifetches;
    perf_ctr_t            perf_ifetch_latency;

    word_t imem [MAX_PROG];
    word_t model_regs [NUM_REGS];
    int    prog_len       = 0;
    int    fetch_count    = 0;
    int    pending_cycles = 0;  // Request-to-response cycles seen by memory
    logic  program_ready  = 1'b0;

    core_top uut (.*);

    bind core_top core_tb_sva port_checks (
        .clk              (clk),
        .reset            (reset),
        .icache_req_valid (icache_req_valid),
        .icache_req_addr  (icache_req_addr),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_ready (icache_rsp_ready),
        .sim_ebreak       (sim_ebreak),
        .sim_wb_value     (sim_wb_value),
        .busy             (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic fail_value(input string name, input word_t got, input word_t exp);
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program builder and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic add_inst(input int kind, input int rd, input int rs1, input int rs2,
                            input int imm);
        word_t w;
        word_t a;
        word_t b;
        word_t res;
        logic  wr;
        a   = model_regs[rs1];
        b   = model_regs[rs2];
        wr  = 1'b1;
        res = '0;
        case (kind)
            K_ADDI: begin
                w   = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
                res = a + word_t'(imm);
            end
            K_ADD: begin
                w   = r_type(7'b0000000, 3'b000, rd, rs1, rs2);
                res = a + b;
            end
            K_SUB: begin
                w   = r_type(7'b0100000, 3'b000, rd, rs1, rs2);
                res = a - b;
            end
            K_AND: begin
                w   = r_type(7'b0000000, 3'b111, rd, rs1, rs2);
                res = a & b;
            end
            K_OR: begin
                w   = r_type(7'b0000000, 3'b110, rd, rs1, rs2);
                res = a | b;
            end
            K_XOR: begin
                w   = r_type(7'b0000000, 3'b100, rd, rs1, rs2);
                res = a ^ b;
            end
            K_SLT: begin
                w   = r_type(7'b0000000, 3'b010, rd, rs1, rs2);
                res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            end
            K_LUI: begin
                w   = {imm[19:0], rd[4:0], 7'b0110111};
                res = {imm[19:0], 12'h000};
            end
            K_BAD: begin
                w  = {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0001011};  // custom-0
                wr = 1'b0;
            end
            default: begin
                w  = 32'h0010_0073;  // EBREAK
                wr = 1'b0;
            end
        endcase
        if (wr && rd != 0) begin
            model_regs[rd] = res;
        end
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        add_inst(K_ADDI, 1, 0, 0, 100);
        add_inst(K_ADDI, 2, 0, 0, -7);
        add_inst(K_ADD, 3, 1, 2, 0);
        add_inst(K_SUB, 4, 2, 1, 0);
        add_inst(K_AND, 5, 1, 3, 0);
        add_inst(K_OR, 6, 1, 2, 0);
        add_inst(K_XOR, 7, 3, 4, 0);
        add_inst(K_SLT, 8, 2, 1, 0);  // Negative vs positive
        add_inst(K_SLT, 9, 1, 2, 0);
        add_inst(K_LUI, 10, 0, 0, 'hABCDE);
        add_inst(K_ADDI, 10, 10, 0, 'h123);
        add_inst(K_ADDI, 0, 1, 0, 5);  // Write to x0 is dropped
        add_inst(K_BAD, 11, 1, 2, 0);
        add_inst(K_ADD, 12, 0, 10, 0);
        add_inst(K_EBREAK, 0, 0, 0, 0);
    endtask

    // Instruction memory with random back-pressure and latency
    task automatic serve_fetches;
        int unsigned delay;
        addr_t       addr;
        int          idx;
        forever begin
            while (!icache_req_valid) begin
                next_cycle();
            end
            addr = icache_req_addr;
            assert (addr == START_ADDR + addr_t'(4 * fetch_count))
                else fail_value("icache_req_addr", addr, START_ADDR + addr_t'(4 * fetch_count));
            delay = $urandom_range(3, 0);
            repeat (delay) begin
                next_cycle();
                assert (icache_req_valid) else fail_plain("request dropped before acceptance");
                assert (icache_req_addr == addr)
                    else fail_value("icache_req_addr", icache_req_addr, addr);
            end
            icache_req_ready = 1'b1;
            next_cycle();
            icache_req_ready = 1'b0;
            fetch_count++;
            idx = (addr - START_ADDR) >> 2;
            assert (addr >= START_ADDR && idx < prog_len)
                else fail_plain("request address lies outside the program");
            delay = $urandom_range(3, 0);
            repeat (delay) begin
                pending_cycles++;
                next_cycle();
            end
            assert (icache_rsp_ready) else fail_plain("response ready low while waiting");
            icache_rsp_valid = 1'b1;
            icache_rsp_data  = imem[idx];
            pending_cycles++;
            next_cycle();
            icache_rsp_valid = 1'b0;
        end
    endtask

    task automatic write_dcr(input dcr_addr_t addr, input word_t data);
        dcr_write_valid = 1'b1;
        dcr_write_addr  = addr;
        dcr_write_data  = data;
        next_cycle();
        dcr_write_valid = 1'b0;
    endtask

    task automatic check_idle;
        assert (!busy) else fail_plain("busy high before start");
        assert (!icache_req_valid) else fail_plain("request issued before start");
        assert (!sim_ebreak) else fail_plain("sim_ebreak high before start");
    endtask

    always @(negedge clk) begin
        if (uut.port_checks.fail_count != 0) begin
            fail_plain("a bound port assertion failed");
        end
    end

    initial begin
        wait (program_ready);
        #((RESET_CYCLES + 200 * prog_len) * CLK_PERIOD);
        $display("%0t ns: timeout, the core never reached ebreak", $time);
        $display("STATUS: FAIL");
        $fatal(1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        void'($urandom(46669));
        reset            = 1'b1;
        dcr_write_valid  = 1'b0;
        dcr_write_addr   = '0;
        dcr_write_data   = '0;
        icache_req_ready = 1'b0;
        icache_rsp_valid = 1'b0;
        icache_rsp_data  = '0;
        build_program();
        program_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();
        check_idle();
        write_dcr(DCR_STARTUP_ADDR + dcr_addr_t'(1), 32'hDEAD_BEEF);  // Wrong address
        repeat (4) begin
            next_cycle();
            check_idle();
        end

        fork
            serve_fetches();
        join_none
        write_dcr(DCR_STARTUP_ADDR, START_ADDR);
        while (!sim_ebreak) begin
            assert (busy) else fail_plain("busy low while the program runs");
            next_cycle();
        end

        for (int r = 0; r < NUM_REGS; r++) begin
            assert (sim_wb_value[r] == model_regs[r])
                else fail_value($sformatf("sim_wb_value[%0d]", r), sim_wb_value[r],
                                model_regs[r]);
        end
        assert (perf_ifetches == perf_ctr_t'(prog_len))
            else fail_value("perf_ifetches", perf_ifetches, prog_len);
        assert (perf_ifetch_latency == perf_ctr_t'(pending_cycles))
            else fail_value("perf_ifetch_latency", perf_ifetch_latency, pending_cycles);

        repeat (8) begin
            next_cycle();
            assert (!sim_ebreak) else fail_plain("sim_ebreak pulsed more than once");
            assert (!busy) else fail_plain("busy high after halt");
            assert (!icache_req_valid) else fail_plain("request issued after halt");
        end

        if (uut.port_checks.fail_count != 0) begin
            $display("%0t ns: bound port assertions failed", $time);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/core_tb_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb_sva import core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 icache_req_valid,
    input  addr_t                icache_req_addr,
    input  logic                 icache_req_ready,
    input  logic                 icache_rsp_ready,
    input  logic                 sim_ebreak,
    input  word_t [NUM_REGS-1:0] sim_wb_value,
    input  logic                 busy
);

    int unsigned fail_count = 0;  // Read by the testbench
    logic        addr_seen;
    logic        halted;
    addr_t       last_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request history
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_seen <= 1'b0;
            halted    <= 1'b0;
        end else begin
            if (icache_req_valid && icache_req_ready) begin
                addr_seen <= 1'b1;
                last_addr <= icache_req_addr;
            end
            if (sim_ebreak) begin
                halted <= 1'b1;
            end
        end
    end

    req_hold: assert property (@(posedge clk) disable iff (reset)
        icache_req_valid && !icache_req_ready |=> icache_req_valid && $stable(icache_req_addr))
        else begin
            fail_count = fail_count + 1;
            $error("request dropped or changed before acceptance");
        end

    // New request follows the last accepted one
    next_addr: assert property (@(posedge clk) disable iff (reset)
        $rose(icache_req_valid) && addr_seen |-> icache_req_addr == last_addr + 32'd4)
        else begin
            fail_count = fail_count + 1;
            $error("request address is not the previous one plus 4");
        end

    one_side: assert property (@(posedge clk) disable iff (reset)
        !(icache_req_valid && icache_rsp_ready))
        else begin
            fail_count = fail_count + 1;
            $error("response ready raised while a request is open");
        end

    halt_quiet: assert property (@(posedge clk) disable iff (reset)
        halted |-> !busy && !icache_req_valid && !sim_ebreak)
        else begin
            fail_count = fail_count + 1;
            $error("core active after ebreak");
        end

    x0_zero: assert property (@(posedge clk) disable iff (reset)
        sim_wb_value[0] == '0)
        else begin
            fail_count = fail_count + 1;
            $error("x0 holds a nonzero value");
        end

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 dcr_write_valid,
    input  dcr_addr_t            dcr_write_addr,
    input  word_t                dcr_write_data,

    output logic                 icache_req_valid,
    output addr_t                icache_req_addr,
    input  logic                 icache_req_ready,

    input  logic                 icache_rsp_valid,
    input  word_t                icache_rsp_data,
    output logic                 icache_rsp_ready,

    output logic                 sim_ebreak,
    output word_t [NUM_REGS-1:0] sim_wb_value,

    output logic                 busy,
    output perf_ctr_t            perf_ifetches,
    output perf_ctr_t            perf_ifetch_latency
);

    logic         fetch_valid;
    word_t        fetch_word;
    decoded_op_t  dec_op;
    word_t        rs1_data;
    word_t        rs2_data;
    exec_result_t exe_result;
    logic         commit_done;
    logic         ebreak_done;

    fetch_unit fetch (
        .clk              (clk),
        .reset            (reset),
        .dcr_write_valid  (dcr_write_valid),
        .dcr_write_addr   (dcr_write_addr),
        .dcr_write_data   (dcr_write_data),
        .icache_req_valid (icache_req_valid),
        .icache_req_addr  (icache_req_addr),
        .icache_req_ready (icache_req_ready),
        .icache_rsp_valid (icache_rsp_valid),
        .icache_rsp_data  (icache_rsp_data),
        .icache_rsp_ready (icache_rsp_ready),
        .fetch_valid      (fetch_valid),
        .fetch_word       (fetch_word),
        .commit_done      (commit_done),
        .ebreak_done      (ebreak_done),
        .busy             (busy)
    );

    inst_decode decode (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word),
        .dec_op      (dec_op)
    );

    alu_unit execute (
        .clk        (clk),
        .reset      (reset),
        .dec_op     (dec_op),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .exe_result (exe_result)
    );

    // Register reads are indexed straight from the decoded op
    commit_unit commit (
        .clk          (clk),
        .reset        (reset),
        .rs1          (dec_op.rs1),
        .rs2          (dec_op.rs2),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .exe_result   (exe_result),
        .commit_done  (commit_done),
        .ebreak_done  (ebreak_done),
        .sim_ebreak   (sim_ebreak),
        .sim_wb_value (sim_wb_value)
    );

    fetch_perf perf (
        .clk                 (clk),
        .reset               (reset),
        .icache_req_valid    (icache_req_valid),
        .icache_req_ready    (icache_req_ready),
        .icache_rsp_valid    (icache_rsp_valid),
        .icache_rsp_ready    (icache_rsp_ready),
        .perf_ifetches       (perf_ifetches),
        .perf_ifetch_latency (perf_ifetch_latency)
    );

endmodule

`default_nettype wire

// ==== rtl/fetch_perf.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_perf import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      icache_req_valid,
    input  logic      icache_req_ready,
    input  logic      icache_rsp_valid,
    input  logic      icache_rsp_ready,
    output perf_ctr_t perf_ifetches,
    output perf_ctr_t perf_ifetch_latency
);

    logic      req_fire;
    logic      rsp_fire;
    perf_ctr_t pending_reads;

    assign req_fire = icache_req_valid && icache_req_ready;
    assign rsp_fire = icache_rsp_valid && icache_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads       <= '0;
            perf_ifetches       <= '0;
            perf_ifetch_latency <= '0;
        end else begin
            pending_reads       <= pending_reads + perf_ctr_t'(req_fire)
                                   - perf_ctr_t'(rsp_fire);
            perf_ifetches       <= perf_ifetches + perf_ctr_t'(req_fire);
            perf_ifetch_latency <= perf_ifetch_latency + pending_reads;  // Reads in flight
        end
    end

endmodule

`default_nettype wire

// ==== rtl/commit_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module commit_unit import core_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    input  reg_idx_t               rs1,
    input  reg_idx_t               rs2,
    output word_t                  rs1_data,
    output word_t                  rs2_data,

    input  exec_result_t           exe_result,

    output logic                   commit_done,
    output logic                   ebreak_done,

    output logic                   sim_ebreak,
    output word_t [NUM_REGS-1:0]   sim_wb_value
);

    word_t [NUM_REGS-1:0] regs;
    logic                 wr_en;

    // x0 is never written so it reads as zero
    assign wr_en = exe_result.valid && exe_result.wb_en && (exe_result.rd != '0);

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback and completion
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (reset) begin
            regs        <= '0;
            commit_done <= 1'b0;
            ebreak_done <= 1'b0;
        end else begin
            if (wr_en) begin
                regs[exe_result.rd] <= exe_result.data;
            end
            commit_done <= exe_result.valid;                         // Back to fetch
            ebreak_done <= exe_result.valid && exe_result.is_ebreak;
        end
    end

    assign sim_ebreak   = ebreak_done;
    assign sim_wb_value = regs;

endmodule

`default_nettype wire

// ==== execute/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit import core_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  decoded_op_t  dec_op,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    output exec_result_t exe_result
);

    word_t        op_b;
    word_t        alu_out;
    exec_result_t result_next;

    assign op_b = dec_op.use_imm ? dec_op.imm : rs2_data;

    always_comb begin
        unique case (dec_op.alu_op)
            ALU_ADD:    alu_out = rs1_data + op_b;
            ALU_SUB:    alu_out = rs1_data - op_b;
            ALU_AND:    alu_out = rs1_data & op_b;
            ALU_OR:     alu_out = rs1_data | op_b;
            ALU_XOR:    alu_out = rs1_data ^ op_b;
            ALU_SLT:    alu_out = word_t'($signed(rs1_data) < $signed(op_b));
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        result_next.valid     = dec_op.valid;
        result_next.rd        = dec_op.rd;
        result_next.wb_en     = dec_op.wb_en;
        result_next.is_ebreak = dec_op.is_ebreak;
        result_next.data      = alu_out;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_result <= '0;
        end else if (dec_op.valid) begin
            exe_result <= result_next;
        end else begin
            exe_result.valid <= 1'b0;  // One-cycle pulse
        end
    end

endmodule

`default_nettype wire

// ==== decode/inst_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decode import core_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_valid,
    input  word_t       fetch_word,
    output decoded_op_t dec_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      u_imm;

    decoded_op_t dec_next;

    assign opcode = fetch_word[6:0];
    assign funct3 = fetch_word[14:12];
    assign funct7 = fetch_word[31:25];
    assign i_imm  = {{20{fetch_word[31]}}, fetch_word[31:20]};
    assign u_imm  = {fetch_word[31:12], 12'b0};

    always_comb begin
        dec_next           = '0;
        dec_next.valid     = 1'b1;  // Unknown encodings still commit
        dec_next.alu_op    = ALU_ADD;
        dec_next.rd        = fetch_word[11:7];
        dec_next.rs1       = fetch_word[19:15];
        dec_next.rs2       = fetch_word[24:20];
        dec_next.imm       = i_imm;

        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == 3'b000) begin  // ADDI only
                    dec_next.use_imm = 1'b1;
                    dec_next.wb_en   = 1'b1;
                end
            end
            OPC_OP: begin
                dec_next.wb_en = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_next.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_next.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: dec_next.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: dec_next.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: dec_next.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: dec_next.alu_op = ALU_SLT;
                    default:              dec_next.wb_en  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec_next.alu_op  = ALU_PASS_B;
                dec_next.imm     = u_imm;
                dec_next.use_imm = 1'b1;
                dec_next.wb_en   = 1'b1;
            end
            OPC_SYSTEM: begin
                // EBREAK is funct12 = 1 with all other fields zero
                dec_next.is_ebreak = (fetch_word[31:20] == 12'h001)
                                     && (fetch_word[19:7] == '0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_op <= '0;
        end else if (fetch_valid) begin
            dec_op <= dec_next;
        end else begin
            dec_op.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      dcr_write_valid,
    input  dcr_addr_t dcr_write_addr,
    input  word_t     dcr_write_data,

    output logic      icache_req_valid,
    output addr_t     icache_req_addr,
    input  logic      icache_req_ready,

    input  logic      icache_rsp_valid,
    input  word_t     icache_rsp_data,
    output logic      icache_rsp_ready,

    output logic      fetch_valid,
    output word_t     fetch_word,

    input  logic      commit_done,
    input  logic      ebreak_done,

    output logic      busy
);

    fetch_state_t state;
    fetch_state_t state_next;
    addr_t        pc;

    logic dcr_start;
    logic req_fire;
    logic rsp_fire;

    // Startup DCR only counts while idle
    assign dcr_start = dcr_write_valid && (dcr_write_addr == DCR_STARTUP_ADDR)
                       && (state == IDLE);
    assign req_fire  = icache_req_valid && icache_req_ready;
    assign rsp_fire  = icache_rsp_valid && icache_rsp_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        unique case (state)
            IDLE: if (dcr_start) state_next = REQ;
            REQ:  if (req_fire) state_next = WAIT;   // Held until accepted
            WAIT: if (rsp_fire) state_next = BUSY;
            BUSY: begin
                if (ebreak_done) begin
                    state_next = HALT;
                end else if (commit_done) begin
                    state_next = REQ;
                end
            end
            HALT: state_next = HALT;                // Only reset leaves
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Startup value lands straight in the PC
    always_ff @(posedge clk) begin
        if (dcr_start) begin
            pc <= dcr_write_data;
        end else if ((state == BUSY) && commit_done) begin
            pc <= pc + addr_t'(4);
        end
    end

    assign icache_req_valid = (state == REQ);
    assign icache_req_addr  = pc;
    assign icache_rsp_ready = (state == WAIT);

    assign fetch_valid = rsp_fire;
    assign fetch_word  = icache_rsp_data;

    assign busy = (state == REQ) || (state == WAIT) || (state == BUSY);

endmodule

`default_nettype wire

// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and DCR map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int XLEN          = 32;
    localparam int NUM_REGS      = 32;
    localparam int REG_BITS      = 5;
    localparam int PERF_CTR_BITS = 32;
    localparam int DCR_ADDR_BITS = 12;

    typedef logic [XLEN-1:0]          word_t;
    typedef logic [XLEN-1:0]          addr_t;
    typedef logic [REG_BITS-1:0]      reg_idx_t;
    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;
    typedef logic [DCR_ADDR_BITS-1:0] dcr_addr_t;

    localparam dcr_addr_t DCR_STARTUP_ADDR = 12'h001;  // Startup PC register

    // RV32I major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        IDLE,
        REQ,
        WAIT,
        BUSY,
        HALT
    } fetch_state_t;

    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        logic     use_imm;
        logic     wb_en;
        logic     is_ebreak;
    } decoded_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     wb_en;
        logic     is_ebreak;
        word_t    data;
    } exec_result_t;

endpackage

`default_nettype wire
